// ==== design/exu_params.svh ====
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// data word and register file index
`define EXU_XLEN 32
`define EXU_REG_IDX_W 5

// data bus beat geometry
`define DBUS_BEAT_W 64
`define DBUS_BEAT_BYTES 8
`define DBUS_OFF_W 3

// return address increment for jal and jalr
`define EXU_LINK_OFFSET 4

`endif

// ==== design/exu_pkg.sv ====
`default_nettype none

`include "exu_params.svh"

package exu_pkg;

	typedef logic [`EXU_XLEN-1:0] data_t;
	typedef logic [`EXU_REG_IDX_W-1:0] reg_idx_t;

	// instruction class as given by the decoder
	typedef enum logic [2:0] {
		kind_alu,
		kind_branch,
		kind_jal,
		kind_jalr,
		kind_load,
		kind_store
	} inst_kind_e;

	// branches reuse these ops, result bit 0 is the condition
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_slt,
		alu_sltu,
		alu_and,
		alu_or,
		alu_xor
	} alu_op_e;

	typedef enum logic [1:0] {
		mem_byte,
		mem_half,
		mem_word
	} mem_size_e;

endpackage

`default_nettype wire

// ==== design/dbus_pkg.sv ====
`default_nettype none

`include "exu_params.svh"

package dbus_pkg;

	typedef logic [`DBUS_BEAT_W-1:0] beat_t;
	typedef logic [`DBUS_BEAT_BYTES-1:0] strb_t;
	typedef logic [`DBUS_OFF_W-1:0] byte_off_t;

	typedef enum logic [1:0] {
		rd_idle,
		rd_addr,
		rd_data,
		rd_done
	} rd_state_e;

	// resp waits for the write response of the current beat
	typedef enum logic [2:0] {
		wr_idle,
		wr_addr,
		wr_data,
		wr_resp,
		wr_done
	} wr_state_e;

endpackage

`default_nettype wire

// ==== design/lsu_req_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface lsu_req_if;
	import exu_pkg::*;

	// request side, held while the memory instruction is pending
	logic req_load;
	logic req_store;
	data_t addr;
	mem_size_e size;
	logic is_unsigned;
	data_t store_data;

	// completion side
	logic done;
	data_t load_data;

	modport stage (
		output req_load, req_store, addr, size, is_unsigned, store_data,
		input done, load_data
	);

	modport unit (
		input req_load, req_store, addr, size, is_unsigned, store_data,
		output done, load_data
	);

endinterface

`default_nettype wire

// ==== design/beat_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface beat_if;
	import exu_pkg::*;
	import dbus_pkg::*;

	// start pulses and per-access beat layout
	logic rd_start;
	logic wr_start;
	logic two_beats;
	data_t base_addr;
	beat_t wdata;
	strb_t strb_first;
	strb_t strb_second;

	// beat events back from the bus side
	logic r_beat;
	logic beat_second;
	beat_t r_data;
	logic xfer_done;

	modport align (
		output rd_start, wr_start, two_beats, base_addr, wdata, strb_first, strb_second,
		input r_beat, beat_second, r_data, xfer_done
	);

	modport master (
		input rd_start, wr_start, two_beats, base_addr, wdata, strb_first, strb_second,
		output r_beat, beat_second, r_data, xfer_done
	);

endinterface

`default_nettype wire

// ==== design/exu_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exu_params.svh"

module exu_stage (
	input logic clock,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input exu_pkg::inst_kind_e in_kind,
	input exu_pkg::alu_op_e in_alu_op,
	input exu_pkg::data_t in_src1,
	input exu_pkg::data_t in_src2,
	input exu_pkg::reg_idx_t in_rd,
	input exu_pkg::data_t in_pc,
	input exu_pkg::data_t in_branch_target,
	input exu_pkg::mem_size_e in_mem_size,
	input logic in_mem_unsigned,
	input exu_pkg::data_t in_store_data,
	output logic done_valid,
	output logic wb_en,
	output exu_pkg::reg_idx_t wb_addr,
	output exu_pkg::data_t wb_data,
	output logic redirect_taken,
	output exu_pkg::data_t redirect_pc,
	lsu_req_if.stage req
);
	import exu_pkg::*;

	logic stage_valid;
	inst_kind_e kind_q;
	alu_op_e alu_op_q;
	data_t src1_q;
	data_t src2_q;
	reg_idx_t rd_q;
	data_t pc_q;
	data_t target_q;
	mem_size_e size_q;
	logic unsigned_q;
	data_t store_data_q;

	alu_op_e op_eff;
	data_t alu_result;
	data_t link_addr;
	logic is_mem;
	logic is_jump;
	logic branch_taken;

	assign is_mem = (kind_q == kind_load) || (kind_q == kind_store);
	assign is_jump = (kind_q == kind_jal) || (kind_q == kind_jalr);

	// memory ops wait for the lsu, everything else finishes in one cycle
	assign done_valid = stage_valid && (!is_mem || req.done);
	assign in_ready = !stage_valid || done_valid;

	always_ff @(posedge clock) begin
		if (reset) begin
			stage_valid <= 1'b0;
		end else if (in_ready) begin
			stage_valid <= in_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid && in_ready) begin
			kind_q <= in_kind;
			alu_op_q <= in_alu_op;
			src1_q <= in_src1;
			src2_q <= in_src2;
			rd_q <= in_rd;
			pc_q <= in_pc;
			target_q <= in_branch_target;
			size_q <= in_mem_size;
			unsigned_q <= in_mem_unsigned;
			store_data_q <= in_store_data;
		end
	end

	// jumps and memory addresses always take the sum
	assign op_eff = (kind_q == kind_alu || kind_q == kind_branch) ? alu_op_q : alu_add;

	always_comb begin
		case (op_eff)
			alu_add: alu_result = src1_q + src2_q;
			alu_sub: alu_result = src1_q - src2_q;
			alu_slt: alu_result = data_t'($signed(src1_q) < $signed(src2_q));
			alu_sltu: alu_result = data_t'(src1_q < src2_q);
			alu_and: alu_result = src1_q & src2_q;
			alu_or: alu_result = src1_q | src2_q;
			alu_xor: alu_result = src1_q ^ src2_q;
			default: alu_result = src1_q + src2_q;
		endcase
	end

	assign branch_taken = (kind_q == kind_branch) && alu_result[0];
	assign link_addr = pc_q + data_t'(`EXU_LINK_OFFSET);

	assign redirect_taken = done_valid && (branch_taken || is_jump);

	// jalr target has bit 0 cleared
	always_comb begin
		if (kind_q == kind_branch) begin
			redirect_pc = target_q;
		end else if (kind_q == kind_jalr) begin
			redirect_pc = {alu_result[`EXU_XLEN-1:1], 1'b0};
		end else begin
			redirect_pc = alu_result;
		end
	end

	assign wb_en = done_valid && (kind_q != kind_branch) && (kind_q != kind_store);
	assign wb_addr = rd_q;
	assign wb_data = is_jump ? link_addr : (kind_q == kind_load) ? req.load_data : alu_result;

	assign req.req_load = stage_valid && (kind_q == kind_load);
	assign req.req_store = stage_valid && (kind_q == kind_store);
	assign req.addr = alu_result;
	assign req.size = size_q;
	assign req.is_unsigned = unsigned_q;
	assign req.store_data = store_data_q;

endmodule

`default_nettype wire

// ==== design/lsu_align.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exu_params.svh"

module lsu_align (
	input logic clock,
	input logic reset,
	lsu_req_if.unit req,
	beat_if.align bus
);
	import exu_pkg::*;
	import dbus_pkg::*;

	byte_off_t offset;
	logic [3:0] size_bytes;
	logic [3:0] size_mask;
	logic [2*`DBUS_BEAT_BYTES-1:0] byte_mask;
	logic [2*`DBUS_BEAT_W-1:0] store_wide;
	logic [2*`DBUS_BEAT_W-1:0] load_wide;
	data_t load_shifted;
	data_t load_value;
	beat_t beat_lo;
	beat_t beat_hi;
	logic launched;
	logic done_q;
	data_t load_data_q;

	assign offset = req.addr[`DBUS_OFF_W-1:0];

	always_comb begin
		case (req.size)
			mem_byte: begin
				size_bytes = 4'd1;
				size_mask = 4'b0001;
			end
			mem_half: begin
				size_bytes = 4'd2;
				size_mask = 4'b0011;
			end
			default: begin
				size_bytes = 4'd4;
				size_mask = 4'b1111;
			end
		endcase
	end

	// bytes past lane 7 belong to the next aligned beat
	assign byte_mask = {{(2*`DBUS_BEAT_BYTES-4){1'b0}}, size_mask} << offset;
	assign store_wide = {{(2*`DBUS_BEAT_W-`EXU_XLEN){1'b0}}, req.store_data} << {offset, 3'b000};

	assign bus.two_beats = ({1'b0, offset} + size_bytes) > 4'(`DBUS_BEAT_BYTES);
	assign bus.base_addr = {req.addr[`EXU_XLEN-1:`DBUS_OFF_W], {`DBUS_OFF_W{1'b0}}};
	assign bus.strb_first = byte_mask[`DBUS_BEAT_BYTES-1:0];
	assign bus.strb_second = byte_mask[2*`DBUS_BEAT_BYTES-1:`DBUS_BEAT_BYTES];
	// wrapped upper lanes share one data word for both beats
	assign bus.wdata = store_wide[`DBUS_BEAT_W-1:0] | store_wide[2*`DBUS_BEAT_W-1:`DBUS_BEAT_W];

	// one start pulse per request, rearmed after done
	always_ff @(posedge clock) begin
		if (reset) begin
			launched <= 1'b0;
		end else if (done_q) begin
			launched <= 1'b0;
		end else if (req.req_load || req.req_store) begin
			launched <= 1'b1;
		end
	end

	assign bus.rd_start = req.req_load && !launched;
	assign bus.wr_start = req.req_store && !launched;

	always_ff @(posedge clock) begin
		if (bus.r_beat) begin
			if (bus.beat_second) begin
				beat_hi <= bus.r_data;
			end else begin
				beat_lo <= bus.r_data;
			end
		end
	end

	assign load_wide = {beat_hi, beat_lo} >> {offset, 3'b000};
	assign load_shifted = load_wide[`EXU_XLEN-1:0];

	// sign taken from the top loaded byte
	always_comb begin
		case (req.size)
			mem_byte: load_value = {{24{!req.is_unsigned && load_shifted[7]}}, load_shifted[7:0]};
			mem_half: load_value = {{16{!req.is_unsigned && load_shifted[15]}}, load_shifted[15:0]};
			default: load_value = load_shifted;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			done_q <= 1'b0;
		end else begin
			done_q <= bus.xfer_done;
		end
	end

	always_ff @(posedge clock) begin
		if (bus.xfer_done) begin
			load_data_q <= load_value;
		end
	end

	assign req.done = done_q;
	assign req.load_data = load_data_q;

endmodule

`default_nettype wire

// ==== design/dbus_master.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "exu_params.svh"

module dbus_master (
	input logic clock,
	input logic reset,
	beat_if.master bus,
	output logic ar_valid,
	input logic ar_ready,
	output exu_pkg::data_t ar_addr,
	input logic r_valid,
	input dbus_pkg::beat_t r_data,
	output logic r_ready,
	output logic aw_valid,
	input logic aw_ready,
	output exu_pkg::data_t aw_addr,
	output logic w_valid,
	input logic w_ready,
	output dbus_pkg::beat_t w_data,
	output dbus_pkg::strb_t w_strb,
	input logic b_valid,
	output logic b_ready
);
	import exu_pkg::*;
	import dbus_pkg::*;

	rd_state_e rd_state;
	rd_state_e rd_next;
	wr_state_e wr_state;
	wr_state_e wr_next;
	logic second;
	logic last_beat;
	data_t beat_addr;

	assign last_beat = !bus.two_beats || second;

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_state <= rd_idle;
			wr_state <= wr_idle;
		end else begin
			rd_state <= rd_next;
			wr_state <= wr_next;
		end
	end

	// read channel, address then data per beat
	always_comb begin
		rd_next = rd_state;
		case (rd_state)
			rd_idle: if (bus.rd_start) rd_next = rd_addr;
			rd_addr: if (ar_ready) rd_next = rd_data;
			rd_data: if (r_valid) rd_next = last_beat ? rd_done : rd_addr;
			rd_done: rd_next = rd_idle;
			default: rd_next = rd_idle;
		endcase
	end

	// write channel, address then data then response per beat
	always_comb begin
		wr_next = wr_state;
		case (wr_state)
			wr_idle: if (bus.wr_start) wr_next = wr_addr;
			wr_addr: if (aw_ready) wr_next = wr_data;
			wr_data: if (w_ready) wr_next = wr_resp;
			wr_resp: if (b_valid) wr_next = last_beat ? wr_done : wr_addr;
			wr_done: wr_next = wr_idle;
			default: wr_next = wr_idle;
		endcase
	end

	// set after the first beat of a split access completes
	always_ff @(posedge clock) begin
		if (reset) begin
			second <= 1'b0;
		end else if (bus.xfer_done) begin
			second <= 1'b0;
		end else if (((rd_state == rd_data && r_valid) || (wr_state == wr_resp && b_valid))
				&& !last_beat) begin
			second <= 1'b1;
		end
	end

	assign beat_addr = second ? bus.base_addr + data_t'(`DBUS_BEAT_BYTES) : bus.base_addr;

	assign ar_valid = (rd_state == rd_addr);
	assign ar_addr = beat_addr;
	assign r_ready = (rd_state == rd_data);

	assign aw_valid = (wr_state == wr_addr);
	assign aw_addr = beat_addr;
	assign w_valid = (wr_state == wr_data);
	assign w_data = bus.wdata;
	assign w_strb = second ? bus.strb_second : bus.strb_first;
	assign b_ready = (wr_state == wr_resp);

	assign bus.r_beat = r_valid && r_ready;
	assign bus.beat_second = second;
	assign bus.r_data = r_data;
	assign bus.xfer_done = (rd_state == rd_done) || (wr_state == wr_done);

endmodule

`default_nettype wire

// ==== design/exu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_top (
	input logic clock,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input exu_pkg::inst_kind_e in_kind,
	input exu_pkg::alu_op_e in_alu_op,
	input exu_pkg::data_t in_src1,
	input exu_pkg::data_t in_src2,
	input exu_pkg::reg_idx_t in_rd,
	input exu_pkg::data_t in_pc,
	input exu_pkg::data_t in_branch_target,
	input exu_pkg::mem_size_e in_mem_size,
	input logic in_mem_unsigned,
	input exu_pkg::data_t in_store_data,
	output logic done_valid,
	output logic wb_en,
	output exu_pkg::reg_idx_t wb_addr,
	output exu_pkg::data_t wb_data,
	output logic redirect_taken,
	output exu_pkg::data_t redirect_pc,
	output logic ar_valid,
	input logic ar_ready,
	output exu_pkg::data_t ar_addr,
	input logic r_valid,
	input dbus_pkg::beat_t r_data,
	output logic r_ready,
	output logic aw_valid,
	input logic aw_ready,
	output exu_pkg::data_t aw_addr,
	output logic w_valid,
	input logic w_ready,
	output dbus_pkg::beat_t w_data,
	output dbus_pkg::strb_t w_strb,
	input logic b_valid,
	output logic b_ready
);

	lsu_req_if req_bus ();
	beat_if beat_bus ();

	exu_stage u_stage (
		.clock(clock),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_kind(in_kind),
		.in_alu_op(in_alu_op),
		.in_src1(in_src1),
		.in_src2(in_src2),
		.in_rd(in_rd),
		.in_pc(in_pc),
		.in_branch_target(in_branch_target),
		.in_mem_size(in_mem_size),
		.in_mem_unsigned(in_mem_unsigned),
		.in_store_data(in_store_data),
		.done_valid(done_valid),
		.wb_en(wb_en),
		.wb_addr(wb_addr),
		.wb_data(wb_data),
		.redirect_taken(redirect_taken),
		.redirect_pc(redirect_pc),
		.req(req_bus.stage)
	);

	// beat layout and load extraction
	lsu_align u_align (
		.clock(clock),
		.reset(reset),
		.req(req_bus.unit),
		.bus(beat_bus.align)
	);

	dbus_master u_master (
		.clock(clock),
		.reset(reset),
		.bus(beat_bus.master),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.ar_addr(ar_addr),
		.r_valid(r_valid),
		.r_data(r_data),
		.r_ready(r_ready),
		.aw_valid(aw_valid),
		.aw_ready(aw_ready),
		.aw_addr(aw_addr),
		.w_valid(w_valid),
		.w_ready(w_ready),
		.w_data(w_data),
		.w_strb(w_strb),
		.b_valid(b_valid),
		.b_ready(b_ready)
	);

endmodule

`default_nettype wire

// ==== tb/mem_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_model (
	input logic clock,
	input logic reset,
	input logic ar_valid,
	output logic ar_ready,
	input exu_pkg::data_t ar_addr,
	output logic r_valid,
	output dbus_pkg::beat_t r_data,
	input logic r_ready,
	input logic aw_valid,
	output logic aw_ready,
	input exu_pkg::data_t aw_addr,
	input logic w_valid,
	output logic w_ready,
	input dbus_pkg::beat_t w_data,
	input dbus_pkg::strb_t w_strb,
	output logic b_valid,
	input logic b_ready
);
	import exu_pkg::*;
	import dbus_pkg::*;

	// 256-byte window, 32 beats of 8 bytes
	beat_t mem [0:31];
	logic [2:0] ar_wait;
	logic [2:0] r_wait;
	logic [2:0] aw_wait;
	logic [2:0] w_wait;
	logic [2:0] b_wait;
	logic rd_pending;
	logic b_pending;
	logic [4:0] rd_word;
	logic [4:0] wr_word;

	initial begin
		for (int i = 0; i < 256; i++) begin
			mem[i / 8][(i % 8) * 8 +: 8] = 8'((i * 29) + 55);
		end
	end

	// read address then read data, each after a random wait
	always @(posedge clock) begin
		if (reset) begin
			ar_ready <= 1'b0;
			r_valid <= 1'b0;
			r_data <= '0;
			rd_pending <= 1'b0;
			ar_wait <= '0;
			r_wait <= '0;
			rd_word <= '0;
		end else begin
			if (ar_valid && ar_ready) begin
				ar_ready <= 1'b0;
				rd_word <= ar_addr[7:3];
				rd_pending <= 1'b1;
				ar_wait <= 3'($urandom_range(4, 0));
			end else if (ar_valid) begin
				if (ar_wait == 0) ar_ready <= 1'b1;
				else ar_wait <= ar_wait - 1;
			end
			if (r_valid && r_ready) begin
				r_valid <= 1'b0;
				r_wait <= 3'($urandom_range(4, 0));
			end else if (rd_pending && !r_valid) begin
				if (r_wait == 0) begin
					r_valid <= 1'b1;
					r_data <= mem[rd_word];
					rd_pending <= 1'b0;
				end else begin
					r_wait <= r_wait - 1;
				end
			end
		end
	end

	// write address, data with strobes, then response
	always @(posedge clock) begin
		if (reset) begin
			aw_ready <= 1'b0;
			w_ready <= 1'b0;
			b_valid <= 1'b0;
			b_pending <= 1'b0;
			aw_wait <= '0;
			w_wait <= '0;
			b_wait <= '0;
			wr_word <= '0;
		end else begin
			if (aw_valid && aw_ready) begin
				aw_ready <= 1'b0;
				wr_word <= aw_addr[7:3];
				aw_wait <= 3'($urandom_range(4, 0));
			end else if (aw_valid) begin
				if (aw_wait == 0) aw_ready <= 1'b1;
				else aw_wait <= aw_wait - 1;
			end
			if (w_valid && w_ready) begin
				w_ready <= 1'b0;
				for (int j = 0; j < 8; j++) begin
					if (w_strb[j]) mem[wr_word][j * 8 +: 8] <= w_data[j * 8 +: 8];
				end
				b_pending <= 1'b1;
				w_wait <= 3'($urandom_range(4, 0));
			end else if (w_valid) begin
				if (w_wait == 0) w_ready <= 1'b1;
				else w_wait <= w_wait - 1;
			end
			if (b_valid && b_ready) begin
				b_valid <= 1'b0;
				b_wait <= 3'($urandom_range(4, 0));
			end else if (b_pending && !b_valid) begin
				if (b_wait == 0) begin
					b_valid <= 1'b1;
					b_pending <= 1'b0;
				end else begin
					b_wait <= b_wait - 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb/exu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_tb;
	import exu_pkg::*;
	import dbus_pkg::*;

	localparam logic [31:0] SEED = 32'h5fbf12ae;
	localparam data_t MEM_BASE = 32'h0000_2000;
	localparam int N_ALU = 40;
	localparam int N_BRANCH = 30;
	localparam int N_ALIGNED = 40;
	localparam int N_CROSS = 24;
	localparam int N_MIXED = 40;
	localparam int N_TOTAL = N_ALU + N_BRANCH + N_ALIGNED + N_CROSS + N_MIXED;
	localparam int CYCLE_LIMIT = 200 * N_TOTAL;

	typedef struct packed {
		logic is_mem;
		logic [31:0] cycle;
		logic wb_en;
		reg_idx_t rd;
		data_t wb_data;
		logic redirect;
		data_t redirect_pc;
	} expect_t;

	logic clock;
	logic reset;
	logic in_valid;
	logic in_ready;
	inst_kind_e in_kind;
	alu_op_e in_alu_op;
	data_t in_src1;
	data_t in_src2;
	reg_idx_t in_rd;
	data_t in_pc;
	data_t in_branch_target;
	mem_size_e in_mem_size;
	logic in_mem_unsigned;
	data_t in_store_data;
	logic done_valid;
	logic wb_en;
	reg_idx_t wb_addr;
	data_t wb_data;
	logic redirect_taken;
	data_t redirect_pc;
	logic ar_valid;
	logic ar_ready;
	data_t ar_addr;
	logic r_valid;
	beat_t r_data;
	logic r_ready;
	logic aw_valid;
	logic aw_ready;
	data_t aw_addr;
	logic w_valid;
	logic w_ready;
	beat_t w_data;
	strb_t w_strb;
	logic b_valid;
	logic b_ready;

	logic [7:0] shadow [0:255];
	expect_t exp_q[$];
	int cycle_count = 0;
	int error_count = 0;
	int check_count = 0;
	int accept_count = 0;
	int done_count = 0;
	int test_count = 0;

	exu_top DUT (.*);
	mem_model mem (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic expect_equal(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		check_count++;
		if (got !== expected) begin
			$display("FAIL %s: got %h expected %h", name, got, expected);
			error_count++;
		end
	endtask

	// expected completion where loads read the shadow copy of memory
	function automatic expect_t predict_completion(inst_kind_e kind, alu_op_e op, data_t s1,
			data_t s2, reg_idx_t rd, data_t pc, data_t target, mem_size_e size, logic uns);
		expect_t e;
		data_t res;
		data_t sum;
		data_t ld;
		int nbytes;
		e = '0;
		e.rd = rd;
		e.is_mem = (kind == kind_load) || (kind == kind_store);
		sum = s1 + s2;
		case (op)
			alu_sub: res = s1 - s2;
			alu_slt: res = ($signed(s1) < $signed(s2)) ? 32'd1 : 32'd0;
			alu_sltu: res = (s1 < s2) ? 32'd1 : 32'd0;
			alu_and: res = s1 & s2;
			alu_or: res = s1 | s2;
			alu_xor: res = s1 ^ s2;
			default: res = sum;
		endcase
		nbytes = (size == mem_byte) ? 1 : (size == mem_half) ? 2 : 4;
		case (kind)
			kind_alu: begin
				e.wb_en = 1'b1;
				e.wb_data = res;
			end
			kind_branch: begin
				e.redirect = res[0];
				e.redirect_pc = target;
			end
			kind_jal, kind_jalr: begin
				e.wb_en = 1'b1;
				e.wb_data = pc + 32'd4;
				e.redirect = 1'b1;
				e.redirect_pc = (kind == kind_jalr) ? (sum & ~32'd1) : sum;
			end
			kind_load: begin
				ld = '0;
				for (int k = 0; k < nbytes; k++) begin
					ld[k * 8 +: 8] = shadow[(sum + data_t'(k)) & 32'hff];
				end
				if (!uns && size == mem_byte && ld[7]) ld = ld | 32'hffff_ff00;
				if (!uns && size == mem_half && ld[15]) ld = ld | 32'hffff_0000;
				e.wb_en = 1'b1;
				e.wb_data = ld;
			end
			default: ;
		endcase
		return e;
	endfunction

	task automatic write_shadow(input data_t addr, input mem_size_e size, input data_t data);
		int nbytes;
		nbytes = (size == mem_byte) ? 1 : (size == mem_half) ? 2 : 4;
		for (int k = 0; k < nbytes; k++) begin
			shadow[(addr + data_t'(k)) & 32'hff] = data[k * 8 +: 8];
		end
	endtask

	// starts and ends 1 ns after a rising edge
	task automatic send(input inst_kind_e kind, input alu_op_e op, input data_t s1,
			input data_t s2, input data_t pc, input data_t target, input mem_size_e size,
			input logic uns, input data_t sdata);
		expect_t e;
		reg_idx_t rd;
		logic accepted;
		int acc_cycle;
		rd = reg_idx_t'($urandom);
		repeat ($urandom_range(2, 0)) begin
			@(posedge clock);
			#1;
		end
		in_valid = 1'b1;
		in_kind = kind;
		in_alu_op = op;
		in_src1 = s1;
		in_src2 = s2;
		in_rd = rd;
		in_pc = pc;
		in_branch_target = target;
		in_mem_size = size;
		in_mem_unsigned = uns;
		in_store_data = sdata;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clock);
			accepted = in_ready;
			acc_cycle = cycle_count;
			@(posedge clock);
			#1;
		end
		in_valid = 1'b0;
		e = predict_completion(kind, op, s1, s2, rd, pc, target, size, uns);
		e.cycle = acc_cycle;
		exp_q.push_back(e);
		accept_count++;
		if (kind == kind_store) write_shadow(s1 + s2, size, sdata);
	endtask

	task automatic drain_and_report(input string name, input int errs_before);
		while (exp_q.size() != 0) @(posedge clock);
		#1;
		test_count++;
		$display("test %s done: %0d errors", name, error_count - errs_before);
	endtask

	// compare process samples between edges
	always @(negedge clock) begin
		expect_t e;
		if (!reset) begin
			if (done_valid) begin
				done_count++;
				if (exp_q.size() == 0) begin
					$display("ERROR: done_valid pulse with no instruction pending");
					error_count++;
				end else begin
					e = exp_q.pop_front();
					if (!e.is_mem && cycle_count != e.cycle + 1) begin
						$display("ERROR: completion came %0d cycles after acceptance",
							cycle_count - e.cycle);
						error_count++;
					end
					expect_equal("wb_en", 32'(wb_en), 32'(e.wb_en));
					if (e.wb_en) begin
						expect_equal("wb_addr", 32'(wb_addr), 32'(e.rd));
						expect_equal("wb_data", wb_data, e.wb_data);
					end
					expect_equal("redirect_taken", 32'(redirect_taken), 32'(e.redirect));
					if (e.redirect) expect_equal("redirect_pc", redirect_pc, e.redirect_pc);
				end
			end else if (exp_q.size() > 0 && in_ready) begin
				$display("ERROR: in_ready high while an instruction is still pending");
				error_count++;
			end
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("ERROR: run stopped by timeout after %0d cycles", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		int errs;
		int unused_seed;
		data_t a;
		int nb;
		int cross_off [4];
		mem_size_e cross_size [4];
		inst_kind_e kind;
		unused_seed = $urandom(SEED);
		cross_off = '{5, 6, 7, 7};
		cross_size = '{mem_word, mem_word, mem_word, mem_half};
		for (int i = 0; i < 256; i++) shadow[i] = 8'((i * 29) + 55);
		reset = 1'b1;
		in_valid = 1'b0;
		in_kind = kind_alu;
		in_alu_op = alu_add;
		in_src1 = '0;
		in_src2 = '0;
		in_rd = '0;
		in_pc = '0;
		in_branch_target = '0;
		in_mem_size = mem_word;
		in_mem_unsigned = 1'b0;
		in_store_data = '0;
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;

		errs = error_count;
		expect_equal("done_valid", 32'(done_valid), 32'd0);
		expect_equal("in_ready", 32'(in_ready), 32'd1);
		expect_equal("wb_en", 32'(wb_en), 32'd0);
		expect_equal("redirect_taken", 32'(redirect_taken), 32'd0);
		expect_equal("bus valids", 32'({ar_valid, aw_valid, w_valid}), 32'd0);
		expect_equal("bus readies", 32'({r_ready, b_ready}), 32'd0);
		drain_and_report("reset", errs);

		errs = error_count;
		for (int i = 0; i < N_ALU; i++) begin
			send(kind_alu, alu_op_e'($urandom_range(6, 0)), $urandom, $urandom,
				$urandom, '0, mem_word, 1'b0, '0);
		end
		drain_and_report("alu", errs);

		errs = error_count;
		for (int i = 0; i < N_BRANCH; i++) begin
			kind = inst_kind_e'($urandom_range(3, 1));
			send(kind, alu_op_e'($urandom_range(6, 0)), $urandom, data_t'($urandom_range(3, 0)),
				$urandom, $urandom, mem_word, 1'b0, '0);
		end
		drain_and_report("branch_jump", errs);

		errs = error_count;
		for (int sz = 0; sz < 3; sz++) begin
			nb = 1 << sz;
			for (int off = 0; off <= 8 - nb; off++) begin
				a = data_t'($urandom_range(29, 0) * 8 + off);
				send(kind_store, alu_add, MEM_BASE, a, '0, '0, mem_size_e'(sz), 1'b0, $urandom);
				send(kind_load, alu_add, MEM_BASE, a, '0, '0, mem_size_e'(sz),
					1'($urandom_range(1, 0)), '0);
			end
		end
		drain_and_report("aligned_mem", errs);

		// loads around the split also cover both neighbouring beats
		errs = error_count;
		for (int c = 0; c < 4; c++) begin
			a = data_t'($urandom_range(29, 0) * 8);
			send(kind_store, alu_add, MEM_BASE, a + cross_off[c], '0, '0, cross_size[c],
				1'b0, $urandom);
			send(kind_load, alu_add, MEM_BASE, a + cross_off[c], '0, '0, cross_size[c],
				1'b0, '0);
			for (int w = 0; w < 4; w++) begin
				send(kind_load, alu_add, MEM_BASE, a + data_t'(w * 4), '0, '0, mem_word,
					1'b1, '0);
			end
		end
		drain_and_report("crossing_mem", errs);

		errs = error_count;
		for (int i = 0; i < N_MIXED; i++) begin
			send(inst_kind_e'($urandom_range(5, 0)), alu_op_e'($urandom_range(6, 0)), MEM_BASE,
				data_t'($urandom_range(239, 0)), $urandom, $urandom,
				mem_size_e'($urandom_range(2, 0)), 1'($urandom_range(1, 0)), $urandom);
		end
		drain_and_report("mixed_backpressure", errs);
		if (done_count != accept_count) begin
			$display("ERROR: %0d instructions accepted but %0d completion pulses seen",
				accept_count, done_count);
			error_count++;
		end

		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== exu_top.f ====
+incdir+design
design/exu_pkg.sv
design/dbus_pkg.sv
design/lsu_req_if.sv
design/beat_if.sv
design/exu_stage.sv
design/lsu_align.sv
design/dbus_master.sv
design/exu_top.sv
tb/mem_model.sv
tb/exu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the execute stage testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module exu_tb -f exu_top.f -o Vexu_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vexu_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0
